// ==== source/siFhPkg.sv ====
`default_nettype none

package siFhPkg;

    // histogram geometry, bins addressed 1..NUM_BINS
    localparam int NUM_BINS = 16;
    // one extra bit so address NUM_BINS fits
    localparam int BIN_ADDR_W = 5;
    localparam int COUNT_W = 8;

    // threshold window half-width in bins
    localparam int WINDOW_HALF = 3;

    // bit positions inside the write enable
    localparam int CH_SEL = 1;
    localparam int FH_SEL = 0;

    typedef logic [BIN_ADDR_W-1:0] binAddrT;
    typedef logic [COUNT_W-1:0]    binCountT;
    // bit 1 coarse, bit 0 fine
    typedef logic [1:0]            hitSelT;

    // saturation level of a bin
    localparam binCountT COUNT_MAX = '1;

    typedef enum logic [1:0] {
        ACQUIRE,
        SCAN,
        FLUSH,
        DONE
    } ctrlStateT;

endpackage

`default_nettype wire

// ==== source/histScanIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface histScanIf import siFhPkg::*; ();

    // scan request from control
    logic     scanEn;
    binAddrT  scanAddr;
    // marks the request for bin NUM_BINS
    logic     scanLast;

    // registered bin contents, one cycle after scanEn
    binCountT countCH;
    binCountT countFH;

    modport ctrl (
        output scanEn,
        output scanAddr,
        output scanLast
    );

    modport bank (
        input  scanEn,
        input  scanAddr,
        output countCH,
        output countFH
    );

    // finder realigns the request with the counts itself
    modport finder (
        input scanEn,
        input scanAddr,
        input scanLast,
        input countCH,
        input countFH
    );

endinterface

`default_nettype wire

// ==== source/binCounterBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module binCounterBank import siFhPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    hitAccept,
    input  hitSelT  wrEn,
    input  binAddrT addr,
    histScanIf.bank scan
);

    // bins live in registers so reset clears them in one cycle
    binCountT binCH [1:NUM_BINS];
    binCountT binFH [1:NUM_BINS];
    // addr 0 means no hit this cycle
    logic     hitValid;

    assign hitValid = hitAccept && (addr != '0);

    // saturating increment of the selected bins
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i <= NUM_BINS; i++) begin
                binCH[i] <= '0;
                binFH[i] <= '0;
            end
        end else if (hitValid) begin
            for (int i = 1; i <= NUM_BINS; i++) begin
                if (addr == binAddrT'(i)) begin
                    // coarse channel
                    if (wrEn[CH_SEL] && (binCH[i] != COUNT_MAX)) begin
                        binCH[i] <= binCH[i] + binCountT'(1);
                    end
                    // fine channel
                    if (wrEn[FH_SEL] && (binFH[i] != COUNT_MAX)) begin
                        binFH[i] <= binFH[i] + binCountT'(1);
                    end
                end
            end
        end
    end

    // scan read port, one cycle latency
    // no hits arrive while scanning, so no bypass needed
    always_ff @(posedge clk) begin
        if (scan.scanEn) begin
            scan.countCH <= binCH[scan.scanAddr];
            scan.countFH <= binFH[scan.scanAddr];
        end
    end

    // hit source must stay inside the bin range
    // hitAccept comes from control, addr from outside
    assert property (
        @(posedge clk) disable iff (!rstN)
        (hitValid && (wrEn != '0)) |-> (addr <= binAddrT'(NUM_BINS))
    ) else begin
        $error("binCounterBank: hit on addr %0d above NUM_BINS", addr);
    end

endmodule

`default_nettype wire

// ==== source/histCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module histCtrl import siFhPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    acqFinish,
    output logic    hitAccept,
    output logic    busy,
    output logic    peakValid,
    histScanIf.ctrl scan
);

    ctrlStateT state;
    ctrlStateT stateNext;

    // next state
    always_comb begin
        stateNext = state;
        case (state)
            ACQUIRE: begin
                if (acqFinish) begin
                    stateNext = SCAN;
                end
            end
            SCAN: begin
                // leave after bin NUM_BINS is requested
                if (scan.scanLast) begin
                    stateNext = FLUSH;
                end
            end
            // one cycle for the bank read latency
            FLUSH: begin
                stateNext = DONE;
            end
            // only reset leaves DONE
            DONE: begin
                stateNext = DONE;
            end
            default: begin
                stateNext = ACQUIRE;
            end
        endcase
    end

    // state, scan address and result strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state         <= ACQUIRE;
            scan.scanAddr <= '0;
            peakValid     <= 1'b0;
        end else begin
            state <= stateNext;
            // 1 on entry to SCAN, then counts up, parks at 0 elsewhere
            scan.scanAddr <= (stateNext == SCAN) ? scan.scanAddr + binAddrT'(1) : '0;
            // finder settles on the DONE entry edge, flag one edge later
            peakValid <= (state == DONE);
        end
    end

    assign scan.scanEn   = (state == SCAN);
    assign scan.scanLast = scan.scanEn && (scan.scanAddr == binAddrT'(NUM_BINS));

    // hits only count while acquiring
    assign hitAccept = (state == ACQUIRE);
    // high from the acqFinish edge until results are flagged
    assign busy = (state != ACQUIRE) && !peakValid;

    // scan never requests the empty address
    assert property (
        @(posedge clk) disable iff (!rstN)
        scan.scanEn |-> (scan.scanAddr != '0) && (scan.scanAddr <= binAddrT'(NUM_BINS))
    ) else begin
        $error("histCtrl: scanAddr %0d out of range during scan", scan.scanAddr);
    end

    // after the last bin: scan stays off through FLUSH and DONE, then peakValid
    assert property (
        @(posedge clk) disable iff (!rstN)
        scan.scanLast |=> !scan.scanEn ##1 !scan.scanEn ##1 (peakValid && !scan.scanEn)
    ) else begin
        $error("histCtrl: scan tail or peakValid timing broken");
    end

endmodule

`default_nettype wire

// ==== source/peakFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

module peakFinder import siFhPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    histScanIf.finder scan,
    output binAddrT   peakCH,
    output binAddrT   peakFH
);

    // scan request delayed to line up with the bank output
    logic     scanEnQ;
    binAddrT  scanAddrQ;
    logic     scanLastQ;
    // set once the last bin has been compared
    logic     holdQ;

    // per channel, indexed like the write enable bits
    binCountT chanCount [2];
    binCountT bestCount [2];
    binAddrT  bestAddr  [2];

    assign chanCount[CH_SEL] = scan.countCH;
    assign chanCount[FH_SEL] = scan.countFH;

    // control part of the delay line
    always_ff @(posedge clk) begin
        if (!rstN) begin
            scanEnQ   <= 1'b0;
            scanLastQ <= 1'b0;
        end else begin
            scanEnQ   <= scan.scanEn;
            scanLastQ <= scan.scanLast;
        end
    end

    // address only matters while scanEnQ is high
    always_ff @(posedge clk) begin
        scanAddrQ <= scan.scanAddr;
    end

    // running maximum
    // strictly greater only, so ties keep the lower address
    // best count starts at 0, empty histogram leaves peak 0
    always_ff @(posedge clk) begin
        if (!rstN) begin
            holdQ <= 1'b0;
            for (int c = 0; c < 2; c++) begin
                bestCount[c] <= '0;
                bestAddr[c]  <= '0;
            end
        end else if (scanEnQ && !holdQ) begin
            for (int c = 0; c < 2; c++) begin
                if (chanCount[c] > bestCount[c]) begin
                    bestCount[c] <= chanCount[c];
                    bestAddr[c]  <= scanAddrQ;
                end
            end
            // freeze after bin NUM_BINS
            if (scanLastQ) begin
                holdQ <= 1'b1;
            end
        end
    end

    assign peakCH = bestAddr[CH_SEL];
    assign peakFH = bestAddr[FH_SEL];

endmodule

`default_nettype wire

// ==== source/thresholdCalc.sv ====
`timescale 1ns/1ps
`default_nettype none

module thresholdCalc import siFhPkg::*; (
    input  binAddrT peakCH,
    output binAddrT thMinus,
    output binAddrT thPositive,
    output binAddrT delta
);

    // unclipped-to-zero window edges
    binAddrT lowEdge;
    binAddrT highEdge;

    always_comb begin
        // lower edge clipped at bin 1
        if (peakCH > binAddrT'(WINDOW_HALF)) begin
            lowEdge = peakCH - binAddrT'(WINDOW_HALF);
        end else begin
            lowEdge = binAddrT'(1);
        end
        // upper edge clipped at NUM_BINS
        if (peakCH > binAddrT'(NUM_BINS - WINDOW_HALF)) begin
            highEdge = binAddrT'(NUM_BINS);
        end else begin
            highEdge = peakCH + binAddrT'(WINDOW_HALF);
        end
    end

    // no coarse peak means no window
    assign thMinus    = (peakCH == '0) ? '0 : lowEdge;
    assign thPositive = (peakCH == '0) ? '0 : highEdge;
    assign delta      = thPositive - thMinus;

    // window never inverts and never exceeds its full width
    always_comb begin
        if (peakCH != '0) begin
            assert ((thMinus <= thPositive) && (delta <= binAddrT'(2 * WINDOW_HALF)))
            else $error("thresholdCalc: bad window %0d..%0d", thMinus, thPositive);
        end
    end

endmodule

`default_nettype wire

// ==== source/histPeakTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module histPeakTop import siFhPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  hitSelT  wrEn,
    input  binAddrT addr,
    input  logic    acqFinish,
    output logic    busy,
    output logic    peakValid,
    output binAddrT peakCH,
    output binAddrT peakFH,
    output binAddrT thMinus,
    output binAddrT thPositive,
    output binAddrT delta
);

    // high while acquiring
    logic hitAccept;

    // scan path between control, bins and finder
    histScanIf scanBus ();

    histCtrl histCtrlU0 (
        .clk       (clk),
        .rstN      (rstN),
        .acqFinish (acqFinish),
        .hitAccept (hitAccept),
        .busy      (busy),
        .peakValid (peakValid),
        .scan      (scanBus.ctrl)
    );

    binCounterBank binCounterBankU0 (
        .clk       (clk),
        .rstN      (rstN),
        .hitAccept (hitAccept),
        .wrEn      (wrEn),
        .addr      (addr),
        .scan      (scanBus.bank)
    );

    peakFinder peakFinderU0 (
        .clk    (clk),
        .rstN   (rstN),
        .scan   (scanBus.finder),
        .peakCH (peakCH),
        .peakFH (peakFH)
    );

    // window follows the coarse peak only
    thresholdCalc thresholdCalcU0 (
        .peakCH     (peakCH),
        .thMinus    (thMinus),
        .thPositive (thPositive),
        .delta      (delta)
    );

endmodule

`default_nettype wire

// ==== dv/histPeakTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module histPeakTb import siFhPkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_RECORDS  = 64;
    localparam int RANDOM_HITS  = 200;
    localparam int SCAN_CYCLES  = NUM_BINS + 4;
    // record kinds in the stim file
    localparam logic [7:0] KIND_HIT    = 8'h01;
    localparam logic [7:0] KIND_FINISH = 8'h02;
    localparam logic [7:0] KIND_EXPECT = 8'h03;
    localparam logic [7:0] KIND_RESET  = 8'h04;
    localparam logic [7:0] KIND_END    = 8'hFF;

    logic    clk;
    logic    rstN;
    hitSelT  wrEn;
    binAddrT addr;
    logic    acqFinish;
    logic    busy;
    logic    peakValid;
    binAddrT peakCH;
    binAddrT peakFH;
    binAddrT thMinus;
    binAddrT thPositive;
    binAddrT delta;

    logic [47:0] stim [MAX_RECORDS];
    int          errors;
    int          budgetCycles;
    logic [31:0] lcgState;
    // reference histograms for the random phase
    int          modelCH [1:NUM_BINS];
    int          modelFH [1:NUM_BINS];

    histPeakTop dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .addr       (addr),
        .acqFinish  (acqFinish),
        .busy       (busy),
        .peakValid  (peakValid),
        .peakCH     (peakCH),
        .peakFH     (peakFH),
        .thMinus    (thMinus),
        .thPositive (thPositive),
        .delta      (delta)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // 32-bit LCG, upper half is the better part
    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkTrue(input bit cond, input string what);
        assert (cond) else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    // one hit per cycle, then back to idle
    task automatic driveHits(input hitSelT sel, input binAddrT a, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            wrEn <= sel;
            addr <= a;
        end
        @(posedge clk);
        wrEn <= '0;
        addr <= '0;
    endtask

    // saturating count, addr 0 is no hit
    task automatic modelAdd(input hitSelT sel, input binAddrT a);
        if (a != '0) begin
            if (sel[1] && (modelCH[int'(a)] < 255)) begin
                modelCH[int'(a)]++;
            end
            if (sel[0] && (modelFH[int'(a)] < 255)) begin
                modelFH[int'(a)]++;
            end
        end
    endtask

    // highest count, lowest address on a tie, 0 when empty
    function automatic int peakOf(input bit coarse);
        int best;
        int bestAddr;
        int c;
        best = 0;
        bestAddr = 0;
        for (int b = 1; b <= NUM_BINS; b++) begin
            c = coarse ? modelCH[b] : modelFH[b];
            if (c > best) begin
                best = c;
                bestAddr = b;
            end
        end
        return bestAddr;
    endfunction

    task automatic checkResults(input int eCH, input int eFH, input int eMinus,
                                input int ePlus, input int eDelta);
        @(negedge clk);
        checkValue("peakCH", eCH, int'(peakCH));
        checkValue("peakFH", eFH, int'(peakFH));
        checkValue("thMinus", eMinus, int'(thMinus));
        checkValue("thPositive", ePlus, int'(thPositive));
        checkValue("delta", eDelta, int'(delta));
    endtask

    // window clipped to 1..NUM_BINS, all zero without a coarse peak
    task automatic checkModel();
        int pCH;
        int lo;
        int hi;
        pCH = peakOf(1'b1);
        lo = (pCH - WINDOW_HALF < 1) ? 1 : pCH - WINDOW_HALF;
        hi = (pCH + WINDOW_HALF > NUM_BINS) ? NUM_BINS : pCH + WINDOW_HALF;
        if (pCH == 0) begin
            lo = 0;
            hi = 0;
        end
        checkResults(pCH, peakOf(1'b0), lo, hi, hi - lo);
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        wrEn <= '0;
        addr <= '0;
        acqFinish <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        for (int b = 1; b <= NUM_BINS; b++) begin
            modelCH[b] = 0;
            modelFH[b] = 0;
        end
        @(negedge clk);
        checkTrue(!busy && !peakValid, "busy or peakValid high after reset");
        checkResults(0, 0, 0, 0, 0);
    endtask

    // pulse acqFinish, measure the scan, keep hitting while it runs
    task automatic finishScan();
        int cycles;
        cycles = 0;
        @(posedge clk);
        acqFinish <= 1'b1;
        @(posedge clk);
        acqFinish <= 1'b0;
        // aimed at the bin that the scan reads last
        wrEn <= 2'b11;
        addr <= binAddrT'(NUM_BINS);
        @(negedge clk);
        while (!peakValid && (cycles <= NUM_BINS + 4)) begin
            checkTrue(busy, "busy low while scanning");
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        checkTrue(peakValid, "peakValid never rose after acqFinish");
        checkValue("peakValid delay", NUM_BINS + 2, cycles);
        checkTrue(!busy, "busy still high with peakValid");
        @(posedge clk);
        wrEn <= '0;
        addr <= '0;
    endtask

    initial begin
        int          idx;
        int          scans;
        int          resets;
        int          hitCycles;
        bit          running;
        logic [47:0] rec;
        logic [15:0] r;
        hitSelT      sel;
        binAddrT     a;
        errors = 0;
        budgetCycles = 0;
        lcgState = 32'd45;
        rstN = 1'b0;
        wrEn = '0;
        addr = '0;
        acqFinish = 1'b0;
        for (int i = 0; i < MAX_RECORDS; i++) begin
            stim[i] = {KIND_END, 40'h0};
        end
        $readmemh("dv/histPeak_stim.txt", stim);

        // watchdog budget from what the tests will do
        scans = 1;
        resets = 3;
        hitCycles = 0;
        for (int i = 0; i < MAX_RECORDS; i++) begin
            if (stim[i][47:40] == KIND_HIT) begin
                hitCycles += int'(stim[i][23:8]) + 1;
            end else if (stim[i][47:40] == KIND_FINISH) begin
                scans++;
            end else if (stim[i][47:40] == KIND_RESET) begin
                resets++;
            end
        end
        budgetCycles = MAX_RECORDS + hitCycles + 2 * RANDOM_HITS
                     + scans * SCAN_CYCLES + resets * (RESET_CYCLES + 4);

        applyReset();
        // directed records
        idx = 0;
        running = 1'b1;
        while (running && (idx < MAX_RECORDS)) begin
            rec = stim[idx];
            case (rec[47:40])
                KIND_HIT: begin
                    driveHits(hitSelT'(rec[39:32]), binAddrT'(rec[31:24]), int'(rec[23:8]));
                end
                KIND_FINISH: begin
                    finishScan();
                end
                KIND_EXPECT: begin
                    checkResults(int'(rec[39:32]), int'(rec[31:24]), int'(rec[23:16]),
                                 int'(rec[15:8]), int'(rec[7:0]));
                end
                KIND_RESET: begin
                    applyReset();
                end
                KIND_END: begin
                    running = 1'b0;
                end
                default: begin
                    $display("error: unknown stim record %h at entry %0d", rec, idx);
                    errors++;
                    running = 1'b0;
                end
            endcase
            idx++;
        end

        // random phase against the reference model
        applyReset();
        for (int i = 0; i < RANDOM_HITS; i++) begin
            r = nextRand();
            sel = hitSelT'(r[1:0]);
            a = binAddrT'(int'(r[15:4]) % (NUM_BINS + 1));
            driveHits(sel, a, 1);
            modelAdd(sel, a);
        end
        finishScan();
        checkModel();
        applyReset();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (budgetCycles != 0);
        #(budgetCycles * CLK_PERIOD * 2);
        $display("timeout: run did not end within %0d cycles", budgetCycles * 2);
        $display("errors: %0d", errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/siFhPkg.sv
source/histScanIf.sv
source/binCounterBank.sv
source/histCtrl.sv
source/peakFinder.sv
source/thresholdCalc.sv
source/histPeakTop.sv
dv/histPeakTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the histogram peak testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=simHistPeak

rm -rf "$OBJ"
verilator --binary --timing --assert -f compile.f --top-module histPeakTb \
    -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== dv/histPeak_stim.txt ====
// kind(2) a(2) b(2) c(4) e(2), hex. 01 hit: a=wrEn b=addr c=repeat. 02 finish
// 03 expect: peakCH peakFH thMinus thPositive delta. 04 reset. ff end
010204000500
01020A000800
01020C000300
010106000700
010102000400
01030A000100
010300001400
020000000000
010304003200
030A06070D06
040000000000
010201000400
010208000400
020000000000
030100010403
040000000000
010202010000
010210019000
010110000300
020000000000
030210010504
040000000000
010210000600
01020F000200
01010F000200
01010E000200
020000000000
03100E0D1003
040000000000
020000000000
030000000000
FF0000000000
